// ==== testbench/testdata_queue_ops.txt ====
// columns (hex): op arg1 arg2 arg3 arg4; 1 write q data, 2 read q, 3 idle, 4 burst q count data0
// 5 write q data and read q2 in one cycle, 6 expect write_full mask, 7 final counts q0 q1 q2 q3
1 0 a001 0 0
1 1 b001 0 0
3 0 0 0 0
1 0 a002 0 0
2 0 0 0 0
1 3 d001 0 0
2 1 0 0 0
1 1 b002 0 0
3 0 0 0 0
2 3 0 0 0
5 0 a003 1 0    // write queue 0 while reading queue 1
5 0 a004 0 0    // write and read queue 0 together
6 0 0 0 0
4 2 3b c000 0   // 59 words fill queue 2 up to the full level
6 4 0 0 0
2 2 0 0 0
6 0 0 0 0
5 2 c03b 2 0
3 0 0 0 0
1 3 d002 0 0
2 0 0 0 0
2 2 0 0 0
1 1 b003 0 0
2 3 0 0 0
3 0 0 0 0
2 1 0 0 0
6 0 0 0 0
7 1 0 39 0

// ==== files.f ====
src/qfifo_pkg.sv
src/queue_write_ctrl.sv
src/queue_read_ctrl.sv
src/read_return_fifo.sv
src/queue_occupancy.sv
src/sram_queue_ctrl.sv
testbench/sram_model.sv
testbench/tb_sram_queue_ctrl.sv

// ==== Makefile ====
# Verilator build and run of the SRAM queue controller testbench
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_sram_queue_ctrl
FILELIST  = files.f
BUILD_DIR = obj_dir
SIM_BIN   = $(BUILD_DIR)/V$(TOP)
SOURCES   = $(shell cat $(FILELIST))
LOG       = sim.log
PASS_LINE = >>> PASS

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -qx -- '$(PASS_LINE)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_sram_queue_ctrl.sv ====
`timescale 1ns/1ps
// testbench for the SRAM queue controller: replays the operation list from the
// data file, keeps a reference queue per queue id and checks data and flags
module tb_sram_queue_ctrl;
    import qfifo_pkg::*;

    localparam int    MAX_RECORDS = 64;
    localparam string DATA_FILE   = "testbench/testdata_queue_ops.txt";

    logic                      clk = 1'b0;
    logic                      reset;
    logic                      write_valid;
    logic [QUEUE_ID_WIDTH-1:0] write_queue_id;
    logic [DATA_WIDTH-1:0]     write_data;
    logic                      write_busy;
    logic [NUM_QUEUES-1:0]     write_full;
    logic                      read_request;
    logic [QUEUE_ID_WIDTH-1:0] read_queue_id;
    logic                      read_busy;
    logic [NUM_QUEUES-1:0]     read_empty;
    logic [DATA_WIDTH-1:0]     read_data;
    logic [QUEUE_ID_WIDTH-1:0] read_data_queue_id;
    logic                      read_data_valid;
    logic                      mem_wr_en;
    logic [ADDR_WIDTH-1:0]     mem_wr_addr;
    logic [MEM_WORD_WIDTH-1:0] mem_wr_word;
    logic                      mem_rd_en;
    logic [ADDR_WIDTH-1:0]     mem_rd_addr;
    logic [MEM_WORD_WIDTH-1:0] mem_rd_word;
    logic                      mem_rd_valid;

    // operation records, five hex words each
    logic [31:0]               ops [MAX_RECORDS*5];

    // reference queues, counted at accept and popped at return
    logic [DATA_WIDTH-1:0]     ref_data [NUM_QUEUES][64];
    logic [5:0]                ref_head [NUM_QUEUES];
    logic [5:0]                ref_tail [NUM_QUEUES];
    int                        ref_count [NUM_QUEUES];
    logic [QUEUE_ID_WIDTH-1:0] read_order [$];

    // read offset of each queue, advanced at every accepted read
    logic [5:0]                rd_issued [NUM_QUEUES];

    int                        record_count = 0;
    int                        timeout_cycles = 0;
    int                        checks = 0;
    int                        errors = 0;
    int                        returned = 0;
    logic [7:0]                lfsr_state = 8'd50;

    always #2 clk = ~clk;

    sram_queue_ctrl #(
        .NUM_QUEUES     (NUM_QUEUES),
        .QUEUE_ID_WIDTH (QUEUE_ID_WIDTH),
        .ADDR_WIDTH     (ADDR_WIDTH),
        .DATA_WIDTH     (DATA_WIDTH)
    ) dut_i (
        .clk                (clk),
        .reset              (reset),
        .write_valid        (write_valid),
        .write_queue_id     (write_queue_id),
        .write_data         (write_data),
        .write_busy         (write_busy),
        .write_full         (write_full),
        .read_request       (read_request),
        .read_queue_id      (read_queue_id),
        .read_busy          (read_busy),
        .read_empty         (read_empty),
        .read_data          (read_data),
        .read_data_queue_id (read_data_queue_id),
        .read_data_valid    (read_data_valid),
        .mem_wr_en          (mem_wr_en),
        .mem_wr_addr        (mem_wr_addr),
        .mem_wr_word        (mem_wr_word),
        .mem_rd_en          (mem_rd_en),
        .mem_rd_addr        (mem_rd_addr),
        .mem_rd_word        (mem_rd_word),
        .mem_rd_valid       (mem_rd_valid)
    );

    sram_model #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .WORD_WIDTH (MEM_WORD_WIDTH),
        .SEED       (8'd50)
    ) sram_i (
        .clk          (clk),
        .mem_wr_en    (mem_wr_en),
        .mem_wr_addr  (mem_wr_addr),
        .mem_wr_word  (mem_wr_word),
        .mem_rd_en    (mem_rd_en),
        .mem_rd_addr  (mem_rd_addr),
        .mem_rd_word  (mem_rd_word),
        .mem_rd_valid (mem_rd_valid)
    );

    // 8 bit Fibonacci LFSR, taps 8 6 5 4
    function automatic logic [7:0] lfsr_next(input logic [7:0] state);
        return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("ERROR @ %0t: %s got %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    // empty flag of each queue follows its reference count
    task automatic check_empty_flags();
        logic [NUM_QUEUES-1:0] expected;
        for (int q = 0; q < NUM_QUEUES; q++)
        begin
            expected[q] = (ref_count[q] == 0);
        end
        check_value(32'(read_empty), 32'(expected), "read_empty");
    endtask

    // memory write follows its accept by one cycle: payload, queue id, valid on top
    task automatic check_mem_write(input logic [ADDR_WIDTH-1:0] addr,
                                   input logic [QUEUE_ID_WIDTH-1:0] q,
                                   input logic [DATA_WIDTH-1:0] data);
        check_value(32'(mem_wr_en), 32'd1, "mem_wr_en");
        check_value(32'(mem_wr_addr), 32'(addr), "mem_wr_addr");
        check_value(32'(mem_wr_word), 32'({1'b1, q, data}), "mem_wr_word");
    endtask

    task automatic check_mem_read(input logic [ADDR_WIDTH-1:0] addr);
        check_value(32'(mem_rd_en), 32'd1, "mem_rd_en");
        check_value(32'(mem_rd_addr), 32'(addr), "mem_rd_addr");
    endtask

    task automatic push_reference(input logic [QUEUE_ID_WIDTH-1:0] q,
                                  input logic [DATA_WIDTH-1:0] data);
        ref_data[q][ref_tail[q]] = data;
        ref_tail[q]  = ref_tail[q] + 1'b1;
        ref_count[q] = ref_count[q] + 1;
    endtask

    task automatic issue_write(input logic [QUEUE_ID_WIDTH-1:0] q,
                               input logic [DATA_WIDTH-1:0] data);
        logic [ADDR_WIDTH-1:0] addr;
        while (write_busy || write_full[q])
        begin
            @(negedge clk);
        end
        // queue id on top, write offset below
        addr           = {q, ref_tail[q]};
        write_valid    = 1'b1;
        write_queue_id = q;
        write_data     = data;
        push_reference(q, data);
        @(negedge clk);
        write_valid = 1'b0;
        check_empty_flags();
        check_mem_write(addr, q, data);
    endtask

    task automatic issue_read(input logic [QUEUE_ID_WIDTH-1:0] q);
        logic [ADDR_WIDTH-1:0] addr;
        while (read_busy || read_empty[q])
        begin
            @(negedge clk);
        end
        addr          = {q, rd_issued[q]};
        read_request  = 1'b1;
        read_queue_id = q;
        read_order.push_back(q);
        rd_issued[q] = rd_issued[q] + 1'b1;
        ref_count[q] = ref_count[q] - 1;
        @(negedge clk);
        read_request = 1'b0;
        check_empty_flags();
        check_mem_read(addr);
    endtask

    // write and read accepted in the same cycle
    task automatic issue_write_read(input logic [QUEUE_ID_WIDTH-1:0] wq,
                                    input logic [DATA_WIDTH-1:0] data,
                                    input logic [QUEUE_ID_WIDTH-1:0] rq);
        logic [ADDR_WIDTH-1:0] wr_addr;
        logic [ADDR_WIDTH-1:0] rd_addr;
        while (write_busy || write_full[wq] || read_busy || read_empty[rq])
        begin
            @(negedge clk);
        end
        wr_addr        = {wq, ref_tail[wq]};
        rd_addr        = {rq, rd_issued[rq]};
        write_valid    = 1'b1;
        write_queue_id = wq;
        write_data     = data;
        read_request   = 1'b1;
        read_queue_id  = rq;
        push_reference(wq, data);
        read_order.push_back(rq);
        rd_issued[rq] = rd_issued[rq] + 1'b1;
        ref_count[rq] = ref_count[rq] - 1;
        @(negedge clk);
        write_valid  = 1'b0;
        read_request = 1'b0;
        check_empty_flags();
        check_mem_write(wr_addr, wq, data);
        check_mem_read(rd_addr);
    endtask

    task automatic idle_gap();
        int gap;
        gap = 1;
        for (int b = 0; b < 2; b++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            gap        = gap + (int'(lfsr_state[0]) << b);
        end
        repeat (gap) @(negedge clk);
    endtask

    //////////////////////////////
    // returned data
    //////////////////////////////

    always @(negedge clk)
    begin
        logic [QUEUE_ID_WIDTH-1:0] q;
        if (!reset && read_data_valid)
        begin
            if (read_order.size() == 0)
            begin
                errors++;
                $display("read data came back on queue %0d with no read pending",
                         read_data_queue_id);
            end
            else
            begin
                q = read_order.pop_front();
                check_value(32'(read_data_queue_id), 32'(q), "returned queue id");
                check_value(32'(read_data), 32'(ref_data[q][ref_head[q]]), "returned payload");
                ref_head[q] = ref_head[q] + 1'b1;
                returned++;
            end
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial
    begin
        logic [31:0] op;
        logic [31:0] a1;
        logic [31:0] a2;
        logic [31:0] a3;
        int          drained;
        reset          = 1'b1;
        write_valid    = 1'b0;
        write_queue_id = '0;
        write_data     = '0;
        read_request   = 1'b0;
        read_queue_id  = '0;
        for (int q = 0; q < NUM_QUEUES; q++)
        begin
            ref_head[q]  = '0;
            ref_tail[q]  = '0;
            ref_count[q] = 0;
            rd_issued[q] = '0;
        end
        $readmemh(DATA_FILE, ops);
        // the final count record closes the list
        while (record_count < MAX_RECORDS && ops[5*record_count] !== 32'h7)
        begin
            record_count++;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);
        check_value(32'({mem_wr_en, mem_rd_en, read_data_valid, write_busy, read_busy}), 32'd0,
                    "control outputs after reset");
        check_value(32'(write_full), 32'd0, "write_full after reset");
        check_value(32'(read_empty), 32'({NUM_QUEUES{1'b1}}), "read_empty after reset");
        if (record_count == MAX_RECORDS)
        begin
            errors++;
            $display("the data file has no final count record");
        end
        else
        begin
            timeout_cycles = (record_count + 1) * 40;
            for (int r = 0; r < record_count; r++)
            begin
                op = ops[5*r];
                a1 = ops[5*r+1];
                a2 = ops[5*r+2];
                a3 = ops[5*r+3];
                case (op)
                    1: issue_write(QUEUE_ID_WIDTH'(a1), DATA_WIDTH'(a2));
                    2: issue_read(QUEUE_ID_WIDTH'(a1));
                    3: idle_gap();
                    4:
                    begin
                        for (int i = 0; i < int'(a2); i++)
                        begin
                            issue_write(QUEUE_ID_WIDTH'(a1), DATA_WIDTH'(a3 + 32'(i)));
                        end
                    end
                    5: issue_write_read(QUEUE_ID_WIDTH'(a1), DATA_WIDTH'(a2), QUEUE_ID_WIDTH'(a3));
                    6:
                    begin
                        // full is registered one cycle behind the count
                        repeat (2) @(negedge clk);
                        check_value(32'(write_full), a1, "write_full");
                    end
                    default:
                    begin
                        errors++;
                        $display("record %0d holds unknown operation %0h", r, op);
                    end
                endcase
            end
            // read every queue dry through the DUT and count what each one held
            for (int q = 0; q < NUM_QUEUES; q++)
            begin
                drained = 0;
                while (!read_empty[q] && drained < 64)
                begin
                    issue_read(QUEUE_ID_WIDTH'(q));
                    drained++;
                end
                check_value(32'(drained), ops[5*record_count+1+q], "final count");
            end
            // let the last reads come back
            while (read_order.size() != 0)
            begin
                @(negedge clk);
            end
            check_empty_flags();
        end
        $display("summary: %0d checks, %0d errors, %0d words returned", checks, errors, returned);
        if (errors == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog, sized from the number of records
    initial
    begin
        wait (timeout_cycles > 0);
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== testbench/sram_model.sv ====
`timescale 1ns/1ps
// behavioral SRAM for the testbench: stores written words and answers reads
// in request order after a random latency of one to four cycles
module sram_model #(
    parameter int         ADDR_WIDTH = 8,
    parameter int         WORD_WIDTH = 19,
    parameter logic [7:0] SEED       = 8'd50
) (
    input  logic                  clk,
    input  logic                  mem_wr_en,
    input  logic [ADDR_WIDTH-1:0] mem_wr_addr,
    input  logic [WORD_WIDTH-1:0] mem_wr_word,
    input  logic                  mem_rd_en,
    input  logic [ADDR_WIDTH-1:0] mem_rd_addr,
    output logic [WORD_WIDTH-1:0] mem_rd_word,
    output logic                  mem_rd_valid
);
    logic [WORD_WIDTH-1:0] mem [2**ADDR_WIDTH];
    logic [ADDR_WIDTH-1:0] pend_addr [$];
    longint                pend_due [$];
    longint                cycle = 0;
    longint                last_due = 0;
    logic [7:0]            lfsr_state = SEED;
    logic                  valid_q = 1'b0;
    logic [WORD_WIDTH-1:0] word_q = '0;

    assign mem_rd_word  = word_q;
    assign mem_rd_valid = valid_q;

    // 8 bit Fibonacci LFSR, taps 8 6 5 4
    function automatic logic [7:0] lfsr_next(input logic [7:0] state);
        return {state[6:0], state[7] ^ state[5] ^ state[4] ^ state[3]};
    endfunction

    always @(posedge clk)
    begin
        longint due;
        cycle = cycle + 1;
        if (mem_wr_en)
        begin
            mem[mem_wr_addr] <= mem_wr_word;
        end
        if (mem_rd_en)
        begin
            // two random bits give one to four cycles
            due = cycle + 1;
            for (int b = 0; b < 2; b++)
            begin
                lfsr_state = lfsr_next(lfsr_state);
                due        = due + (longint'(lfsr_state[0]) << b);
            end
            // never overtake an older read
            if (due <= last_due)
            begin
                due = last_due + 1;
            end
            last_due = due;
            pend_addr.push_back(mem_rd_addr);
            pend_due.push_back(due);
        end
        if (pend_due.size() != 0 && pend_due[0] == cycle)
        begin
            word_q  <= mem[pend_addr[0]];
            valid_q <= 1'b1;
            void'(pend_addr.pop_front());
            void'(pend_due.pop_front());
        end
        else
        begin
            valid_q <= 1'b0;
        end
    end

endmodule

// ==== src/sram_queue_ctrl.sv ====
`timescale 1ns/1ps
// top level of the SRAM queue controller: four FIFO queues in one external
// SRAM, with a write port, a read port and the memory request/return ports
module sram_queue_ctrl #(
    parameter int NUM_QUEUES     = qfifo_pkg::NUM_QUEUES,
    parameter int QUEUE_ID_WIDTH = qfifo_pkg::QUEUE_ID_WIDTH,
    parameter int ADDR_WIDTH     = qfifo_pkg::ADDR_WIDTH,
    parameter int DATA_WIDTH     = qfifo_pkg::DATA_WIDTH
) (
    input  logic                                 clk,
    input  logic                                 reset,

    // upstream write port
    input  logic                                 write_valid,
    input  logic [QUEUE_ID_WIDTH-1:0]            write_queue_id,
    input  logic [DATA_WIDTH-1:0]                write_data,
    output logic                                 write_busy,
    output logic [NUM_QUEUES-1:0]                write_full,

    // downstream read port
    input  logic                                 read_request,
    input  logic [QUEUE_ID_WIDTH-1:0]            read_queue_id,
    output logic                                 read_busy,
    output logic [NUM_QUEUES-1:0]                read_empty,
    output logic [DATA_WIDTH-1:0]                read_data,
    output logic [QUEUE_ID_WIDTH-1:0]            read_data_queue_id,
    output logic                                 read_data_valid,

    // SRAM side
    output logic                                 mem_wr_en,
    output logic [ADDR_WIDTH-1:0]                mem_wr_addr,
    output logic [qfifo_pkg::MEM_WORD_WIDTH-1:0] mem_wr_word,
    output logic                                 mem_rd_en,
    output logic [ADDR_WIDTH-1:0]                mem_rd_addr,
    input  logic [qfifo_pkg::MEM_WORD_WIDTH-1:0] mem_rd_word,
    input  logic                                 mem_rd_valid
);

    // accept events toward the occupancy counters
    logic                      write_accept;
    logic [QUEUE_ID_WIDTH-1:0] write_accept_qid;
    logic                      read_accept;
    logic [QUEUE_ID_WIDTH-1:0] read_accept_qid;

    queue_write_ctrl #(
        .NUM_QUEUES     (NUM_QUEUES),
        .QUEUE_ID_WIDTH (QUEUE_ID_WIDTH),
        .ADDR_WIDTH     (ADDR_WIDTH),
        .DATA_WIDTH     (DATA_WIDTH)
    ) write_ctrl_i (
        .clk             (clk),
        .reset           (reset),
        .write_valid     (write_valid),
        .write_queue_id  (write_queue_id),
        .write_data      (write_data),
        .full            (write_full),
        .write_busy      (write_busy),
        .write_accept    (write_accept),
        .accept_queue_id (write_accept_qid),
        .mem_wr_en       (mem_wr_en),
        .mem_wr_addr     (mem_wr_addr),
        .mem_wr_word     (mem_wr_word)
    );

    queue_read_ctrl #(
        .NUM_QUEUES     (NUM_QUEUES),
        .QUEUE_ID_WIDTH (QUEUE_ID_WIDTH),
        .ADDR_WIDTH     (ADDR_WIDTH)
    ) read_ctrl_i (
        .clk             (clk),
        .reset           (reset),
        .read_request    (read_request),
        .read_queue_id   (read_queue_id),
        .empty           (read_empty),
        .read_busy       (read_busy),
        .read_accept     (read_accept),
        .accept_queue_id (read_accept_qid),
        .mem_rd_en       (mem_rd_en),
        .mem_rd_addr     (mem_rd_addr)
    );

    // counts combine both sides and feed the flags back to them
    queue_occupancy #(
        .NUM_QUEUES     (NUM_QUEUES),
        .QUEUE_ID_WIDTH (QUEUE_ID_WIDTH),
        .ADDR_WIDTH     (ADDR_WIDTH)
    ) occupancy_i (
        .clk            (clk),
        .reset          (reset),
        .write_accept   (write_accept),
        .write_queue_id (write_accept_qid),
        .read_accept    (read_accept),
        .read_queue_id  (read_accept_qid),
        .empty          (read_empty),
        .full           (write_full)
    );

    read_return_fifo #(
        .QUEUE_ID_WIDTH (QUEUE_ID_WIDTH),
        .DATA_WIDTH     (DATA_WIDTH),
        .DEPTH_BITS     (2)
    ) return_fifo_i (
        .clk                (clk),
        .reset              (reset),
        .mem_rd_word        (mem_rd_word),
        .mem_rd_valid       (mem_rd_valid),
        .read_data          (read_data),
        .read_data_queue_id (read_data_queue_id),
        .read_data_valid    (read_data_valid)
    );

endmodule

// ==== src/queue_occupancy.sv ====
`timescale 1ns/1ps
// per-queue word counts fed by the accept events of both sides; gives the
// empty flags straight from the counts and registered full flags
module queue_occupancy #(
    parameter int NUM_QUEUES     = qfifo_pkg::NUM_QUEUES,
    parameter int QUEUE_ID_WIDTH = qfifo_pkg::QUEUE_ID_WIDTH,
    parameter int ADDR_WIDTH     = qfifo_pkg::ADDR_WIDTH
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      write_accept,
    input  logic [QUEUE_ID_WIDTH-1:0] write_queue_id,
    input  logic                      read_accept,
    input  logic [QUEUE_ID_WIDTH-1:0] read_queue_id,
    output logic [NUM_QUEUES-1:0]     empty,
    output logic [NUM_QUEUES-1:0]     full
);
    import qfifo_pkg::*;

    localparam int OFFSET_WIDTH = ADDR_WIDTH - QUEUE_ID_WIDTH;
    localparam int REGION_SIZE  = 2 ** OFFSET_WIDTH;

    // one extra bit so a completely used region still fits
    localparam int COUNT_WIDTH  = OFFSET_WIDTH + 1;

    localparam logic [COUNT_WIDTH-1:0] FULL_LEVEL = COUNT_WIDTH'(REGION_SIZE - FULL_MARGIN);

    //////////////////////////////
    // one counter per queue
    //////////////////////////////

    for (genvar q = 0; q < NUM_QUEUES; q++)
    begin : g_queue
        logic                   inc;
        logic                   dec;
        logic [COUNT_WIDTH-1:0] count;
        logic                   full_reg;

        assign inc = write_accept && (write_queue_id == QUEUE_ID_WIDTH'(q));
        assign dec = read_accept && (read_queue_id == QUEUE_ID_WIDTH'(q));

        always_ff @(posedge clk)
        begin
            if (reset)
            begin
                count    <= '0;
                full_reg <= 1'b0;
            end
            else
            begin
                // a write and a read on this queue in one cycle cancel out
                case ({inc, dec})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
                // one cycle behind the count
                full_reg <= (count >= FULL_LEVEL);
            end
        end

        assign empty[q] = (count == '0);
        assign full[q]  = full_reg;
    end

endmodule

// ==== src/read_return_fifo.sv ====
`timescale 1ns/1ps
// fall-through FIFO for words coming back from the SRAM; the head is popped
// every cycle it is present and split into payload, queue id and valid tag
module read_return_fifo #(
    parameter int QUEUE_ID_WIDTH = qfifo_pkg::QUEUE_ID_WIDTH,
    parameter int DATA_WIDTH     = qfifo_pkg::DATA_WIDTH,
    parameter int DEPTH_BITS     = 2
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [qfifo_pkg::MEM_WORD_WIDTH-1:0] mem_rd_word,
    input  logic                                 mem_rd_valid,
    output logic [DATA_WIDTH-1:0]                read_data,
    output logic [QUEUE_ID_WIDTH-1:0]            read_data_queue_id,
    output logic                                 read_data_valid
);
    import qfifo_pkg::*;

    localparam int DEPTH = 2 ** DEPTH_BITS;

    logic [MEM_WORD_WIDTH-1:0] fifo_mem [DEPTH];
    logic [DEPTH_BITS-1:0]     wr_ptr;
    logic [DEPTH_BITS-1:0]     rd_ptr;
    logic [DEPTH_BITS:0]       depth;
    logic [MEM_WORD_WIDTH-1:0] head_word;
    logic                      fifo_empty;
    logic                      push;
    logic                      pop;

    assign fifo_empty = (depth == '0);
    assign push       = mem_rd_valid;
    // no back-pressure downstream, so the head leaves as soon as it shows
    assign pop        = !fifo_empty;

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            fifo_mem[wr_ptr] <= mem_rd_word;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            depth  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   depth <= depth + 1'b1;
                2'b01:   depth <= depth - 1'b1;
                default: depth <= depth;
            endcase
        end
    end

    // head word decode
    assign head_word          = fifo_mem[rd_ptr];
    assign read_data          = head_word[MEM_DATA_LSB +: DATA_WIDTH];
    assign read_data_queue_id = head_word[MEM_QID_LSB +: QUEUE_ID_WIDTH];
    assign read_data_valid    = !fifo_empty && head_word[MEM_VALID_BIT];

endmodule

// ==== src/queue_read_ctrl.sv ====
`timescale 1ns/1ps
// read side of the queue controller: takes queue requests from the downstream
// arbiter and issues one registered memory read at that queue's read pointer
module queue_read_ctrl #(
    parameter int NUM_QUEUES     = qfifo_pkg::NUM_QUEUES,
    parameter int QUEUE_ID_WIDTH = qfifo_pkg::QUEUE_ID_WIDTH,
    parameter int ADDR_WIDTH     = qfifo_pkg::ADDR_WIDTH
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      read_request,
    input  logic [QUEUE_ID_WIDTH-1:0] read_queue_id,
    input  logic [NUM_QUEUES-1:0]     empty,
    output logic                      read_busy,
    output logic                      read_accept,
    output logic [QUEUE_ID_WIDTH-1:0] accept_queue_id,
    output logic                      mem_rd_en,
    output logic [ADDR_WIDTH-1:0]     mem_rd_addr
);
    import qfifo_pkg::*;

    // offset bits inside one queue region
    localparam int OFFSET_WIDTH = ADDR_WIDTH - QUEUE_ID_WIDTH;

    burst_state_t            burst_state;
    burst_state_t            next_burst_state;
    logic [OFFSET_WIDTH-1:0] rd_offset [NUM_QUEUES];
    logic [ADDR_WIDTH-1:0]   rd_addr_sel;

    //////////////////////////////
    // request decode
    //////////////////////////////

    // requests to an empty queue or during the rest cycle are dropped
    assign read_accept     = read_request && (burst_state == BURST_OFF) && !empty[read_queue_id];
    assign accept_queue_id = read_queue_id;

    assign next_burst_state = read_accept ? BURST_HALFWAY : BURST_OFF;

    // high in the accept cycle and in the halfway cycle that follows
    assign read_busy = (next_burst_state == BURST_HALFWAY) || (burst_state == BURST_HALFWAY);

    // region base comes from the queue id in the top bits
    assign rd_addr_sel = {read_queue_id, rd_offset[read_queue_id]};

    //////////////////////////////
    // pointers and pacing
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            burst_state <= BURST_OFF;
            mem_rd_en   <= 1'b0;
            for (int q = 0; q < NUM_QUEUES; q++)
            begin
                rd_offset[q] <= '0;
            end
        end
        else
        begin
            burst_state <= next_burst_state;
            mem_rd_en   <= read_accept;
            // only the chosen queue moves, the others hold
            if (read_accept)
            begin
                rd_offset[read_queue_id] <= rd_offset[read_queue_id] + 1'b1;
            end
        end
    end

    // address goes out together with mem_rd_en
    always_ff @(posedge clk)
    begin
        if (read_accept)
        begin
            mem_rd_addr <= rd_addr_sel;
        end
    end

endmodule

// ==== src/queue_write_ctrl.sv ====
`timescale 1ns/1ps
// write side of the queue controller: paces upstream writes and issues one
// registered memory write per accepted word at that queue's write pointer
module queue_write_ctrl #(
    parameter int NUM_QUEUES     = qfifo_pkg::NUM_QUEUES,
    parameter int QUEUE_ID_WIDTH = qfifo_pkg::QUEUE_ID_WIDTH,
    parameter int ADDR_WIDTH     = qfifo_pkg::ADDR_WIDTH,
    parameter int DATA_WIDTH     = qfifo_pkg::DATA_WIDTH
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 write_valid,
    input  logic [QUEUE_ID_WIDTH-1:0]            write_queue_id,
    input  logic [DATA_WIDTH-1:0]                write_data,
    input  logic [NUM_QUEUES-1:0]                full,
    output logic                                 write_busy,
    output logic                                 write_accept,
    output logic [QUEUE_ID_WIDTH-1:0]            accept_queue_id,
    output logic                                 mem_wr_en,
    output logic [ADDR_WIDTH-1:0]                mem_wr_addr,
    output logic [qfifo_pkg::MEM_WORD_WIDTH-1:0] mem_wr_word
);
    import qfifo_pkg::*;

    // offset bits inside one queue region
    localparam int OFFSET_WIDTH = ADDR_WIDTH - QUEUE_ID_WIDTH;

    burst_state_t              burst_state;
    burst_state_t              next_burst_state;
    logic [OFFSET_WIDTH-1:0]   wr_offset [NUM_QUEUES];
    logic [MEM_WORD_WIDTH-1:0] packed_word;

    // a word is taken only in the off state and only if its queue has room
    assign write_accept    = write_valid && (burst_state == BURST_OFF) && !full[write_queue_id];
    assign accept_queue_id = write_queue_id;

    assign next_burst_state = write_accept ? BURST_HALFWAY : BURST_OFF;

    // busy covers the accept cycle and the halfway cycle after it
    assign write_busy = (next_burst_state == BURST_HALFWAY) || (burst_state == BURST_HALFWAY);

    // stored word: payload, queue id, valid tag
    always_comb
    begin
        packed_word = '0;
        packed_word[MEM_DATA_LSB +: DATA_WIDTH]    = write_data;
        packed_word[MEM_QID_LSB +: QUEUE_ID_WIDTH] = write_queue_id;
        packed_word[MEM_VALID_BIT]                 = 1'b1;
    end

    //////////////////////////////
    // pointers and pacing
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            burst_state <= BURST_OFF;
            mem_wr_en   <= 1'b0;
            for (int q = 0; q < NUM_QUEUES; q++)
            begin
                wr_offset[q] <= '0;
            end
        end
        else
        begin
            burst_state <= next_burst_state;
            mem_wr_en   <= write_accept;
            // offset wraps inside the region, queue id stays on top
            if (write_accept)
            begin
                wr_offset[write_queue_id] <= wr_offset[write_queue_id] + 1'b1;
            end
        end
    end

    // memory write address and word, loaded on accept
    always_ff @(posedge clk)
    begin
        if (write_accept)
        begin
            mem_wr_addr <= {write_queue_id, wr_offset[write_queue_id]};
            mem_wr_word <= packed_word;
        end
    end

endmodule

// ==== src/qfifo_pkg.sv ====
// shared sizes, the pacing state and the memory word layout of the SRAM queue
// controller; modules import it and the top level takes its defaults from here
package qfifo_pkg;

    //////////////////////////////
    // default sizes
    //////////////////////////////

    localparam int NUM_QUEUES     = 4;
    localparam int QUEUE_ID_WIDTH = 2;

    // 8 address bits and a 2 bit queue id leave 64 words per queue region
    localparam int ADDR_WIDTH     = 8;

    // payload bits carried per queue entry
    localparam int DATA_WIDTH     = 16;

    // full flag rises this many words short of the region size
    localparam int FULL_MARGIN    = 5;

    //////////////////////////////
    // memory word layout
    //////////////////////////////

    // payload at the bottom, queue id right above it, valid tag on top
    localparam int MEM_DATA_LSB   = 0;
    localparam int MEM_QID_LSB    = MEM_DATA_LSB + DATA_WIDTH;
    localparam int MEM_VALID_BIT  = MEM_QID_LSB + QUEUE_ID_WIDTH;

    // full stored word, as seen on both memory ports
    localparam int MEM_WORD_WIDTH = MEM_VALID_BIT + 1;

    //////////////////////////////
    // pacing
    //////////////////////////////

    // each side rests for one cycle after every accept
    typedef enum logic {
        BURST_OFF     = 1'b0,
        BURST_HALFWAY = 1'b1
    } burst_state_t;

endpackage
